/* verilog.f */
+incdir+.
sprite_pkg.sv
hit_list_reader.sv
sprite_meta_fetch.sv
sprite_row_fetch.sv
sprite_blitter.sv
sprite_render.sv
tb_sprite_render.sv

/* Makefile */
# Verilator build and run for the sprite line renderer
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_sprite_render
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q -F '$(PASS_TEXT)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_sprite_render.sv */
`timescale 1ns/1ps
// ********************
// hit list, metadata, VRAM and line buffer are modeled here
// VRAM answers after a random 1 to 6 cycles, one request at a time
// ********************
`include "sprite_macros.svh"

module tb_sprite_render;
    import sprite_pkg::*;

    localparam int PERIOD = 40;
    localparam int DRIVE = 5;
    localparam int LINE_TIMEOUT = 40000;
    localparam int NUM_LINES = 12;

    logic                   clk;
    logic                   rst_n;
    logic                   restart;
    logic [`SPR_HIT_AW-1:0] hit_list_read_address;
    sprite_id_t             sprite_id;
    logic [3:0]             line_offset;
    logic                   width_select;
    logic                   hit_list_ended;
    sprite_id_t             sprite_meta_address;
    logic [9:0]             character;
    logic [3:0]             palette;
    logic [1:0]             pixel_priority;
    screen_x_t              target_x;
    logic                   flip_x;
    vram_addr_t             vram_base_address;
    logic                   vram_read_req;
    vram_addr_t             vram_read_address;
    pixel_row_t             vram_read_data;
    logic                   vram_data_valid;
    logic                   line_buffer_write_en;
    screen_x_t              line_buffer_write_address;
    line_pixel_t            line_buffer_write_data;
    logic                   line_done;

    // memory models
    logic [7:0]  hit_id [0:511];
    logic [3:0]  hit_off [0:511];
    logic        hit_wide [0:511];
    logic        hit_last [0:511];
    logic [9:0]  meta_char [0:255];
    logic [3:0]  meta_pal [0:255];
    logic [1:0]  meta_prio [0:255];
    logic [9:0]  meta_x [0:255];
    logic        meta_flip [0:255];
    logic [31:0] vram [0:16383];
    logic [9:0]  captured [0:1023];
    logic [9:0]  expected [0:1023];

    logic [31:0]            lfsr_state;
    logic [`SPR_HIT_AW-1:0] hit_addr_q;
    sprite_id_t             meta_addr_q;
    vram_addr_t             req_addr;
    int                     req_delay;

    sprite_render dut0 (
        .clk, .rst_n, .restart,
        .hit_list_read_address, .sprite_id, .line_offset, .width_select, .hit_list_ended,
        .sprite_meta_address, .character, .palette, .pixel_priority, .target_x, .flip_x,
        .vram_base_address, .vram_read_req, .vram_read_address, .vram_read_data,
        .vram_data_valid, .line_buffer_write_en, .line_buffer_write_address,
        .line_buffer_write_data, .line_done
    );

    always #(PERIOD / 2) clk = ~clk;

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic fail_run(input string what);
        $display("ERROR: %s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // hit list RAM, address latched in the cycle, data one edge later
    always @(negedge clk) hit_addr_q = hit_list_read_address;
    always @(posedge clk) begin
        #DRIVE;
        sprite_id = hit_id[hit_addr_q];
        line_offset = hit_off[hit_addr_q];
        width_select = hit_wide[hit_addr_q];
        hit_list_ended = hit_last[hit_addr_q];
    end

    // metadata table with one cycle of latency
    always @(negedge clk) meta_addr_q = sprite_meta_address;
    always @(posedge clk) begin
        #DRIVE;
        character = meta_char[meta_addr_q];
        palette = meta_pal[meta_addr_q];
        pixel_priority = meta_prio[meta_addr_q];
        target_x = meta_x[meta_addr_q];
        flip_x = meta_flip[meta_addr_q];
    end

    // VRAM answers each request pulse after a random delay
    always begin
        @(negedge clk);
        if (vram_read_req) begin
            req_addr = vram_read_address;
            req_delay = 1 + int'(rand_bits(3) % 6);
            repeat (req_delay) @(posedge clk);
            #DRIVE;
            vram_read_data = vram[req_addr];
            vram_data_valid = 1'b1;
            @(posedge clk);
            #DRIVE;
            vram_data_valid = 1'b0;
        end
    end

    // line buffer capture, writes are stable in mid cycle
    always @(negedge clk) begin
        if (rst_n && line_buffer_write_en) begin
            if (line_done) begin
                fail_run("line buffer written after line_done");
            end
            captured[line_buffer_write_address] = line_buffer_write_data;
        end
    end

    task automatic wait_line_done;
        int cycles;
        cycles = 0;
        while (!line_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > LINE_TIMEOUT) begin
                fail_run("line_done did not rise before the timeout");
            end
        end
    endtask

    // reference line: entries in order until the end flag or 256 entries
    task automatic build_expected;
        logic [13:0] addr;
        logic [31:0] word;
        logic [9:0]  xs;
        logic [3:0]  colour;
        logic [7:0]  id;
        int          i;
        for (int x = 0; x < 1024; x++) begin
            expected[x] = '0;
        end
        i = 0;
        while (i < 256 && !hit_last[i]) begin
            id = hit_id[i];
            for (int half = 0; half < 2; half++) begin
                if (half == 0 || hit_wide[i]) begin
                    addr = vram_base_address + 14'({meta_char[id], 3'b000})
                         + 14'(hit_off[i][2:0])
                         + (hit_off[i][3] ? 14'(`SPR_ROW_OFFSET) : 14'd0)
                         + ((half == 1) ? 14'd8 : 14'd0);
                    word = vram[addr];
                    xs = meta_x[id] + ((half[0] ^ meta_flip[id]) ? 10'd8 : 10'd0);
                    for (int p = 0; p < 8; p++) begin
                        colour = meta_flip[id] ? word[4*p +: 4] : word[28-4*p +: 4];
                        if (colour != 4'h0) begin
                            expected[xs + 10'(p)] = {meta_prio[id], meta_pal[id], colour};
                        end
                    end
                end
            end
            i++;
        end
    endtask

    // mode 0 plain 8-pixel, 1 flip and wide, 2 near x 1023,
    // 3 early end flag, 4 no end flag
    task automatic run_line(input int line_no, input int mode);
        int          end_pos;
        logic [3:0]  nib;
        logic [31:0] word;
        end_pos = (mode == 3) ? int'(rand_bits(6)) : 1 + int'(rand_bits(5));
        if (mode == 4) begin
            end_pos = 512;
        end
        for (int i = 0; i < 512; i++) begin
            hit_id[i] = 8'(rand_bits(8));
            hit_off[i] = 4'(rand_bits(4));
            hit_wide[i] = (mode == 0) ? 1'b0 : rand_bits(1) != 0;
            hit_last[i] = (i == end_pos);
        end
        for (int s = 0; s < 256; s++) begin
            meta_char[s] = 10'(rand_bits(10));
            meta_pal[s] = 4'(rand_bits(4));
            meta_prio[s] = 2'(rand_bits(2));
            meta_x[s] = (mode == 2) ? 10'd1008 + 10'(rand_bits(4)) : 10'(rand_bits(10));
            meta_flip[s] = (mode == 0) ? 1'b0 : rand_bits(1) != 0;
        end
        // roughly half of the pixels transparent
        for (int a = 0; a < 16384; a++) begin
            word = '0;
            for (int p = 0; p < 8; p++) begin
                nib = (rand_bits(1) != 0) ? 4'(rand_bits(4)) : 4'h0;
                word = {word[27:0], nib};
            end
            vram[a] = word;
        end
        for (int x = 0; x < 1024; x++) begin
            captured[x] = '0;
        end
        $display("line %0d mode %0d end entry %0d", line_no, mode, end_pos);

        @(posedge clk);
        #DRIVE;
        vram_base_address = 14'(rand_bits(14));
        restart = 1'b1;
        @(posedge clk);
        #DRIVE;
        restart = 1'b0;
        @(negedge clk);
        check_value("line_done", 32'(line_done), 32'h0);
        check_value("vram_read_req", 32'(vram_read_req), 32'h0);
        check_value("line_buffer_write_en", 32'(line_buffer_write_en), 32'h0);

        wait_line_done();
        // stray writes after line_done are caught by the capture block
        repeat (16) @(negedge clk);
        build_expected();
        for (int x = 0; x < 1024; x++) begin
            check_value($sformatf("line_buffer[%0d]", x), 32'(captured[x]), 32'(expected[x]));
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        restart = 1'b0;
        sprite_id = '0;
        line_offset = '0;
        width_select = 1'b0;
        hit_list_ended = 1'b0;
        character = '0;
        palette = '0;
        pixel_priority = '0;
        target_x = '0;
        flip_x = 1'b0;
        vram_base_address = '0;
        vram_read_data = '0;
        vram_data_valid = 1'b0;
        lfsr_state = 32'h898a;
        hit_addr_q = '0;
        meta_addr_q = '0;
        // empty list until the first line is filled
        for (int i = 0; i < 512; i++) begin
            hit_id[i] = '0;
            hit_off[i] = '0;
            hit_wide[i] = 1'b0;
            hit_last[i] = 1'b1;
        end
        for (int s = 0; s < 256; s++) begin
            meta_char[s] = '0;
            meta_pal[s] = '0;
            meta_prio[s] = '0;
            meta_x[s] = '0;
            meta_flip[s] = 1'b0;
        end
        for (int a = 0; a < 16384; a++) begin
            vram[a] = '0;
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("line_done", 32'(line_done), 32'h0);
        check_value("vram_read_req", 32'(vram_read_req), 32'h0);
        check_value("line_buffer_write_en", 32'(line_buffer_write_en), 32'h0);
        @(posedge clk);
        #DRIVE;
        rst_n = 1'b1;
        wait_line_done();

        for (int n = 0; n < NUM_LINES; n++) begin
            run_line(n, n % 5);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* sprite_render.sv */
`timescale 1ns/1ps
// ********************
// renders one scanline of sprites, restart begins a new line
// later sprites overwrite earlier ones, no priority resolution
// line_done holds until the next restart
// ********************
`include "sprite_macros.svh"

module sprite_render (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    restart,
    output logic [`SPR_HIT_AW-1:0]  hit_list_read_address,
    input  sprite_pkg::sprite_id_t  sprite_id,
    input  logic [3:0]              line_offset,
    input  logic                    width_select,
    input  logic                    hit_list_ended,
    output sprite_pkg::sprite_id_t  sprite_meta_address,
    input  logic [9:0]              character,
    input  logic [3:0]              palette,
    input  logic [1:0]              pixel_priority,
    input  sprite_pkg::screen_x_t   target_x,
    input  logic                    flip_x,
    input  sprite_pkg::vram_addr_t  vram_base_address,
    output logic                    vram_read_req,
    output sprite_pkg::vram_addr_t  vram_read_address,
    input  sprite_pkg::pixel_row_t  vram_read_data,
    input  logic                    vram_data_valid,
    output logic                    line_buffer_write_en,
    output sprite_pkg::screen_x_t   line_buffer_write_address,
    output sprite_pkg::line_pixel_t line_buffer_write_data,
    output logic                    line_done
);
    import sprite_pkg::*;

    logic       hit_valid;
    logic       hit_ready;
    sprite_id_t hit_sprite_id;
    logic [3:0] hit_line_offset;
    logic       hit_width_select;
    logic       hit_end;

    logic       meta_valid;
    logic       meta_ready;
    logic [9:0] meta_character;
    logic [3:0] meta_palette;
    logic [1:0] meta_priority;
    screen_x_t  meta_target_x;
    logic       meta_flip;
    logic [3:0] meta_line_offset;
    logic       meta_width_select;
    logic       list_finished;

    logic       row_valid;
    logic       row_ready;
    pixel_row_t row_pixels;
    logic [3:0] row_palette;
    logic [1:0] row_priority;
    screen_x_t  row_x_start;
    logic       row_flip;
    logic       fetch_idle;
    logic       blit_idle;

    hit_list_reader reader0 (
        .clk, .rst_n, .restart, .hit_ready,
        .sprite_id, .line_offset, .width_select, .hit_list_ended,
        .hit_list_read_address, .hit_valid, .hit_sprite_id,
        .hit_line_offset, .hit_width_select, .hit_end
    );

    sprite_meta_fetch meta0 (
        .clk, .rst_n, .restart,
        .hit_valid, .hit_sprite_id, .hit_line_offset, .hit_width_select, .hit_end,
        .character, .palette, .pixel_priority, .target_x, .flip_x, .meta_ready,
        .hit_ready, .sprite_meta_address, .meta_valid, .meta_character,
        .meta_palette, .meta_priority, .meta_target_x, .meta_flip,
        .meta_line_offset, .meta_width_select, .list_finished
    );

    sprite_row_fetch fetch0 (
        .clk, .rst_n, .restart,
        .meta_valid, .meta_character, .meta_palette, .meta_priority, .meta_target_x,
        .meta_flip, .meta_line_offset, .meta_width_select,
        .vram_base_address, .vram_read_data, .vram_data_valid, .row_ready,
        .meta_ready, .vram_read_req, .vram_read_address, .row_valid, .row_pixels,
        .row_palette, .row_priority, .row_x_start, .row_flip, .fetch_idle
    );

    sprite_blitter blit0 (
        .clk, .rst_n, .restart,
        .row_valid, .row_pixels, .row_palette, .row_priority, .row_x_start, .row_flip,
        .row_ready, .line_buffer_write_en, .line_buffer_write_address,
        .line_buffer_write_data, .blit_idle
    );

    // the end entry only passes an idle metadata stage, so the downstream
    // idle flags cover every sprite still in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_done <= 1'b0;
        end else if (restart) begin
            line_done <= 1'b0;
        end else if (list_finished && fetch_idle && blit_idle) begin
            line_done <= 1'b1;
        end
    end

endmodule

/* sprite_blitter.sv */
`timescale 1ns/1ps
// ********************
// takes a row only when idle, then writes eight pixel slots back to back
// colour 0 is transparent, x wraps at the end of the line buffer
// ********************

module sprite_blitter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    restart,
    input  logic                    row_valid,
    input  sprite_pkg::pixel_row_t  row_pixels,
    input  logic [3:0]              row_palette,
    input  logic [1:0]              row_priority,
    input  sprite_pkg::screen_x_t   row_x_start,
    input  logic                    row_flip,
    output logic                    row_ready,
    output logic                    line_buffer_write_en,
    output sprite_pkg::screen_x_t   line_buffer_write_address,
    output sprite_pkg::line_pixel_t line_buffer_write_data,
    output logic                    blit_idle
);
    import sprite_pkg::*;

    logic       busy;
    logic [2:0] pixel_count;
    pixel_row_t shifter;
    logic       flip_q;
    logic [3:0] palette_q;
    logic [1:0] priority_q;
    logic [3:0] colour;
    logic       row_take;

    assign row_ready = !busy;
    assign blit_idle = !busy;
    assign row_take = row_valid && row_ready;

    // flipped rows go out from the bottom nibble
    assign colour = flip_q ? shifter[3:0] : shifter[31:28];
    assign line_buffer_write_en = busy && (colour != 4'h0);

    always_comb begin
        line_buffer_write_data.prio = priority_q;
        line_buffer_write_data.palette = palette_q;
        line_buffer_write_data.colour = colour;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pixel_count <= '0;
        end else if (restart) begin
            busy <= 1'b0;
            pixel_count <= '0;
        end else if (row_take) begin
            busy <= 1'b1;
            pixel_count <= 3'd7;
        end else if (busy) begin
            if (pixel_count == '0) begin
                busy <= 1'b0;
            end else begin
                pixel_count <= pixel_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_take) begin
            shifter <= row_pixels;
            flip_q <= row_flip;
            palette_q <= row_palette;
            priority_q <= row_priority;
            line_buffer_write_address <= row_x_start;
        end else if (busy) begin
            shifter <= flip_q ? (shifter >> 4) : (shifter << 4);
            // wraps from 1023 to 0
            line_buffer_write_address <= line_buffer_write_address + 1'b1;
        end
    end

endmodule

/* sprite_row_fetch.sv */
`timescale 1ns/1ps
// ********************
// one VRAM request outstanding, answered by a single data valid pulse
// 16-pixel sprites read their second row only after the first is handed on
// ********************
`include "sprite_macros.svh"

module sprite_row_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   restart,
    input  logic                   meta_valid,
    input  logic [9:0]             meta_character,
    input  logic [3:0]             meta_palette,
    input  logic [1:0]             meta_priority,
    input  sprite_pkg::screen_x_t  meta_target_x,
    input  logic                   meta_flip,
    input  logic [3:0]             meta_line_offset,
    input  logic                   meta_width_select,
    input  sprite_pkg::vram_addr_t vram_base_address,
    input  sprite_pkg::pixel_row_t vram_read_data,
    input  logic                   vram_data_valid,
    input  logic                   row_ready,
    output logic                   meta_ready,
    output logic                   vram_read_req,
    output sprite_pkg::vram_addr_t vram_read_address,
    output logic                   row_valid,
    output sprite_pkg::pixel_row_t row_pixels,
    output logic [3:0]             row_palette,
    output logic [1:0]             row_priority,
    output sprite_pkg::screen_x_t  row_x_start,
    output logic                   row_flip,
    output logic                   fetch_idle
);
    import sprite_pkg::*;

    logic       busy;
    logic       waiting;
    logic       second_half;
    logic       wide;
    screen_x_t  target_x_q;
    vram_addr_t row_address;
    logic       meta_take;
    logic       data_take;
    logic       row_take;

    assign meta_ready = !busy;
    assign fetch_idle = !busy;
    assign meta_take = meta_valid && meta_ready;
    assign data_take = waiting && vram_data_valid;
    assign row_take = row_valid && row_ready;

    // eight words per character, lower 8 rows of a tall character sit further on
    assign row_address = vram_base_address
                       + vram_addr_t'({meta_character, 3'b000})
                       + vram_addr_t'(meta_line_offset[2:0])
                       + (meta_line_offset[3] ? vram_addr_t'(`SPR_ROW_OFFSET) : vram_addr_t'(0));

    // the right-hand half lands 8 pixels on, halves swap under flip
    assign row_x_start = target_x_q + ((second_half ^ row_flip) ? screen_x_t'(8) : screen_x_t'(0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            waiting <= 1'b0;
            second_half <= 1'b0;
            vram_read_req <= 1'b0;
            row_valid <= 1'b0;
        end else if (restart) begin
            busy <= 1'b0;
            waiting <= 1'b0;
            second_half <= 1'b0;
            vram_read_req <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            vram_read_req <= 1'b0;
            if (meta_take) begin
                busy <= 1'b1;
                waiting <= 1'b1;
                second_half <= 1'b0;
                vram_read_req <= 1'b1;
            end else if (data_take) begin
                waiting <= 1'b0;
                row_valid <= 1'b1;
            end else if (row_take) begin
                row_valid <= 1'b0;
                if (wide && !second_half) begin
                    second_half <= 1'b1;
                    waiting <= 1'b1;
                    vram_read_req <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (meta_take) begin
            vram_read_address <= row_address;
            wide <= meta_width_select;
            target_x_q <= meta_target_x;
            row_palette <= meta_palette;
            row_priority <= meta_priority;
            row_flip <= meta_flip;
        end else if (row_take && wide && !second_half) begin
            // right half of the row is the next character
            vram_read_address <= vram_read_address + vram_addr_t'(8);
        end
        if (data_take) begin
            row_pixels <= vram_read_data;
        end
    end

endmodule

/* sprite_meta_fetch.sv */
`timescale 1ns/1ps
// ********************
// metadata port has fixed latency, the address is held until capture
// one entry at a time, nothing accepted after an end entry until restart
// ********************
`include "sprite_macros.svh"

module sprite_meta_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   restart,
    input  logic                   hit_valid,
    input  sprite_pkg::sprite_id_t hit_sprite_id,
    input  logic [3:0]             hit_line_offset,
    input  logic                   hit_width_select,
    input  logic                   hit_end,
    input  logic [9:0]             character,
    input  logic [3:0]             palette,
    input  logic [1:0]             pixel_priority,
    input  sprite_pkg::screen_x_t  target_x,
    input  logic                   flip_x,
    input  logic                   meta_ready,
    output logic                   hit_ready,
    output sprite_pkg::sprite_id_t sprite_meta_address,
    output logic                   meta_valid,
    output logic [9:0]             meta_character,
    output logic [3:0]             meta_palette,
    output logic [1:0]             meta_priority,
    output sprite_pkg::screen_x_t  meta_target_x,
    output logic                   meta_flip,
    output logic [3:0]             meta_line_offset,
    output logic                   meta_width_select,
    output logic                   list_finished
);
    localparam int CNT_W = $clog2(`SPR_META_LATENCY + 1);

    logic             loading;
    logic [CNT_W-1:0] wait_count;
    logic             hit_take;
    logic             meta_load;

    assign hit_ready = !loading && !meta_valid && !list_finished;
    assign hit_take = hit_valid && hit_ready;
    assign meta_load = loading && (wait_count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loading <= 1'b0;
            wait_count <= '0;
            meta_valid <= 1'b0;
            list_finished <= 1'b0;
        end else if (restart) begin
            loading <= 1'b0;
            wait_count <= '0;
            meta_valid <= 1'b0;
            list_finished <= 1'b0;
        end else if (hit_take) begin
            // an end entry carries no sprite
            if (hit_end) begin
                list_finished <= 1'b1;
            end else begin
                loading <= 1'b1;
                wait_count <= CNT_W'(`SPR_META_LATENCY);
            end
        end else if (loading) begin
            if (wait_count != '0) begin
                wait_count <= wait_count - 1'b1;
            end else begin
                loading <= 1'b0;
                meta_valid <= 1'b1;
            end
        end else if (meta_valid && meta_ready) begin
            meta_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_take) begin
            sprite_meta_address <= hit_sprite_id;
            meta_line_offset <= hit_line_offset;
            meta_width_select <= hit_width_select;
        end
        if (meta_load) begin
            meta_character <= character;
            meta_palette <= palette;
            meta_priority <= pixel_priority;
            meta_target_x <= target_x;
            meta_flip <= flip_x;
        end
    end

endmodule

/* hit_list_reader.sv */
`timescale 1ns/1ps
// ********************
// hit list RAM is synchronous, data follows the address by one cycle
// at most one entry every two cycles, address restarts at 0 on restart
// ********************
`include "sprite_macros.svh"

module hit_list_reader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   restart,
    input  logic                   hit_ready,
    input  sprite_pkg::sprite_id_t sprite_id,
    input  logic [3:0]             line_offset,
    input  logic                   width_select,
    input  logic                   hit_list_ended,
    output logic [`SPR_HIT_AW-1:0] hit_list_read_address,
    output logic                   hit_valid,
    output sprite_pkg::sprite_id_t hit_sprite_id,
    output logic [3:0]             hit_line_offset,
    output logic                   hit_width_select,
    output logic                   hit_end
);
    // set once the RAM has latched the current address
    logic data_ready;
    logic capture;

    assign capture = data_ready && !hit_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_list_read_address <= '0;
            data_ready <= 1'b0;
            hit_valid <= 1'b0;
        end else if (restart) begin
            hit_list_read_address <= '0;
            data_ready <= 1'b0;
            hit_valid <= 1'b0;
        end else if (hit_valid) begin
            // entry taken, move on and issue the next read
            if (hit_ready) begin
                hit_valid <= 1'b0;
                hit_list_read_address <= hit_list_read_address + 1'b1;
            end
        end else if (data_ready) begin
            hit_valid <= 1'b1;
            data_ready <= 1'b0;
        end else begin
            data_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hit_sprite_id <= sprite_id;
            hit_line_offset <= line_offset;
            hit_width_select <= width_select;
            // running past 256 entries also ends the list
            hit_end <= hit_list_ended | hit_list_read_address[`SPR_HIT_AW-1];
        end
    end

endmodule

/* sprite_pkg.sv */
// ********************
// shared types for the sprite line renderer
// sizes come from the macros header
// ********************
`include "sprite_macros.svh"

package sprite_pkg;

    typedef logic [7:0] sprite_id_t;

    typedef logic [`SPR_VRAM_AW-1:0] vram_addr_t;

    typedef logic [`SPR_X_W-1:0] screen_x_t;

    // eight 4-bit pixels, leftmost pixel in bits 31:28
    typedef logic [31:0] pixel_row_t;

    // one line buffer entry, colour 0 is transparent
    typedef struct packed {
        logic [1:0] prio;
        logic [3:0] palette;
        logic [3:0] colour;
    } line_pixel_t;

endpackage

/* sprite_macros.svh */
// ********************
// widths, latencies and VRAM row spacing for the sprite line renderer
// SPR_META_LATENCY must be at least 1
// ********************
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// VRAM word address width
`define SPR_VRAM_AW 14
// line buffer address width, 1024 positions
`define SPR_X_W 10
// hit list address width, bit 8 flags the 256-entry limit
`define SPR_HIT_AW 9
// cycles from metadata address to attribute data
`define SPR_META_LATENCY 1
// word distance from the top half of a 16-row character to its lower half
`define SPR_ROW_OFFSET 128

`endif
